//--- logic/pong_field_pkg.sv
`default_nettype none

package pong_field_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // screen coordinates and ball state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [9:0]        coord_t;  // pixel coordinate.
    typedef logic signed [9:0] vel_t;    // pixels per step.

    typedef enum logic [1:0] {
        pingpong = 2'd0,
        soccer   = 2'd1,
        basket   = 2'd2
    } ball_kind_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } ball_pos_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam coord_t STEP_X       = 10'd10;   // horizontal move per step.
    localparam coord_t X_SERVE      = 10'd20;
    localparam coord_t X_RESET      = 10'd10;
    localparam coord_t Y_RESET      = 10'd80;
    localparam coord_t EDGE_MARGIN  = 10'd20;   // right side loss line.
    localparam coord_t FIELD_W_FULL = 10'd640;
    localparam coord_t FIELD_W_HALF = 10'd320;
    localparam coord_t FIELD_H_FULL = 10'd480;
    localparam coord_t FIELD_H_HALF = 10'd240;

endpackage

`default_nettype wire

//--- logic/pong_link_pkg.sv
`default_nettype none

package pong_link_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // serve message from the other board
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        pong_field_pkg::coord_t     y;              // entry height.
        pong_field_pkg::vel_t       vy;             // initial vertical speed.
        logic [1:0]                 grav_phase;
        pong_field_pkg::ball_kind_t kind;
        logic [19:0]                serve_period;   // clocks per step in a serve flight.
        logic [19:0]                return_period;  // clocks per step after a hit.
    } serve_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // engine state and events to the scorer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        idle         = 3'd0,
        wait_release = 3'd1,
        fly_right    = 3'd2,
        fly_left     = 3'd3,
        stopped      = 3'd4,
        send         = 3'd5
    } engine_phase_t;

    typedef struct packed {
        engine_phase_t        phase;
        logic                 returned;  // ball reached the left edge.
        pong_field_pkg::vel_t vy;
    } rally_evt_t;

endpackage

`default_nettype wire

//--- logic/serve_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module serve_decoder #(
    parameter logic [19:0] TICK_BASE = 20'd600000
) (
    input  wire logic                  clk_25MHZ,
    input  wire logic                  reset,
    input  wire logic [7:0]            reg_y0,
    input  wire logic [7:0]            reg_y1,
    input  wire logic signed [7:0]     reg_yspeed,
    input  wire logic [7:0]            reg_gravity,
    input  wire logic [7:0]            reg_kind,
    input  wire logic [9:0]            estimated_speed,
    output pong_link_pkg::serve_t      serve
);

    // flight periods per ball kind as 9/20, 12/20 and 26/20 of the base tick.
    localparam logic [19:0] PERIOD_PINGPONG = 20'((32'(TICK_BASE) * 9) / 20);
    localparam logic [19:0] PERIOD_SOCCER   = 20'((32'(TICK_BASE) * 12) / 20);
    localparam logic [19:0] PERIOD_BASKET   = 20'((32'(TICK_BASE) * 26) / 20);

    pong_link_pkg::serve_t serve_next;
    logic [9:0]            safe_speed;

    always_comb begin
        safe_speed = (estimated_speed < 10'd2) ? 10'd1 : estimated_speed;

        serve_next.y          = {reg_y0[7:6], reg_y1};
        serve_next.vy         = pong_field_pkg::vel_t'(reg_yspeed);  // sign extended.
        serve_next.grav_phase = reg_gravity[1:0];

        case (reg_kind[2:1])
            2'd1: begin
                serve_next.kind         = pong_field_pkg::soccer;
                serve_next.serve_period = PERIOD_SOCCER;
            end
            2'd2: begin
                serve_next.kind         = pong_field_pkg::basket;
                serve_next.serve_period = PERIOD_BASKET;
            end
            default: begin
                serve_next.kind         = pong_field_pkg::pingpong;
                serve_next.serve_period = PERIOD_PINGPONG;
            end
        endcase

        serve_next.return_period = TICK_BASE / {10'd0, safe_speed};  // shorter for faster swings.
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            serve <= '0;
        end else begin
            serve <= serve_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/ball_engine.sv
`timescale 1ns/100ps
`default_nettype none

module ball_engine (
    input  wire logic                  clk_25MHZ,
    input  wire logic                  reset,
    input  wire logic                  upscale,
    input  wire logic                  go_right,
    input  wire logic                  collision_detected,
    input  wire pong_link_pkg::serve_t serve,
    output pong_field_pkg::ball_pos_t  pos,
    output logic                       moving_right,
    output pong_link_pkg::rally_evt_t  evt
);

    pong_link_pkg::engine_phase_t phase;
    pong_field_pkg::vel_t         vy;
    logic [1:0]                   grav_phase;
    logic [19:0]                  step_cnt;
    logic [19:0]                  period;

    pong_field_pkg::coord_t       y_max;
    pong_field_pkg::coord_t       x_limit;
    logic                         step_due;
    logic signed [11:0]           y_sum;
    pong_field_pkg::vel_t         vy_grav;
    pong_field_pkg::ball_pos_t    step_pos;
    pong_field_pkg::vel_t         step_vy;
    logic [1:0]                   step_grav;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one flight step for both directions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign moving_right = (phase == pong_link_pkg::fly_right);
    assign step_due     = (step_cnt >= period);
    assign x_limit      = (upscale ? pong_field_pkg::FIELD_W_FULL : pong_field_pkg::FIELD_W_HALF)
                          - pong_field_pkg::EDGE_MARGIN;
    assign y_max        = (upscale ? pong_field_pkg::FIELD_H_FULL : pong_field_pkg::FIELD_H_HALF)
                          - 10'd1;

    always_comb begin
        step_grav = grav_phase + 2'd1;  // wraps 3 to 0.
        vy_grav   = (grav_phase == 2'd3) ? vy + 10'sd1 : vy;

        if (moving_right) begin
            step_pos.x = pos.x + pong_field_pkg::STEP_X;
        end else if (pos.x >= pong_field_pkg::STEP_X) begin
            step_pos.x = pos.x - pong_field_pkg::STEP_X;
        end else begin
            step_pos.x = '0;
        end

        y_sum = $signed({2'b00, pos.y}) + $signed({{2{vy[9]}}, vy});  // old vy moves y.

        if (y_sum >= $signed({2'b00, y_max})) begin
            step_pos.y = y_max;    // bottom bounce.
            step_vy    = -vy_grav;
        end else if (y_sum <= 12'sd0) begin
            step_pos.y = '0;       // top bounce.
            step_vy    = -vy_grav;
        end else begin
            step_pos.y = y_sum[9:0];
            step_vy    = vy_grav;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flight FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            phase      <= pong_link_pkg::idle;
            pos.x      <= pong_field_pkg::X_RESET;
            pos.y      <= pong_field_pkg::Y_RESET;
            vy         <= '0;
            grav_phase <= '0;
            step_cnt   <= '0;
            period     <= '0;
        end else begin
            case (phase)
                pong_link_pkg::idle: begin
                    if (go_right) begin
                        phase      <= pong_link_pkg::wait_release;
                        pos.x      <= pong_field_pkg::X_SERVE;
                        pos.y      <= serve.y;
                        vy         <= serve.vy;
                        grav_phase <= serve.grav_phase;
                        period     <= serve.serve_period;
                        step_cnt   <= '0;
                    end
                end

                pong_link_pkg::wait_release: begin
                    if (!go_right) begin
                        phase <= pong_link_pkg::fly_right;  // launch on release.
                    end
                end

                pong_link_pkg::fly_right: begin
                    if (collision_detected) begin
                        phase    <= pong_link_pkg::fly_left;
                        step_cnt <= '0;
                        period   <= serve.return_period;
                    end else if (pos.x >= x_limit) begin
                        phase <= pong_link_pkg::stopped;    // missed ball.
                    end else if (step_due) begin
                        pos        <= step_pos;
                        vy         <= step_vy;
                        grav_phase <= step_grav;
                        step_cnt   <= '0;
                    end else begin
                        step_cnt <= step_cnt + 20'd1;
                    end
                end

                pong_link_pkg::fly_left: begin
                    if (collision_detected) begin
                        period <= serve.return_period;
                    end
                    if (pos.x == '0) begin
                        phase    <= pong_link_pkg::send;
                        step_cnt <= '0;
                        period   <= serve.serve_period;
                    end else if (step_due) begin
                        pos        <= step_pos;
                        vy         <= step_vy;
                        grav_phase <= step_grav;
                        step_cnt   <= '0;
                    end else begin
                        step_cnt <= step_cnt + 20'd1;
                    end
                end

                pong_link_pkg::stopped: begin
                    if (go_right) begin
                        phase <= pong_link_pkg::idle;
                    end
                end

                pong_link_pkg::send: begin
                    phase <= pong_link_pkg::idle;  // single hand-off cycle.
                end

                default: begin
                    phase <= pong_link_pkg::idle;
                end
            endcase
        end
    end

    assign evt.phase    = phase;
    assign evt.returned = (phase == pong_link_pkg::send);
    assign evt.vy       = vy;

endmodule

`default_nettype wire

//--- logic/rally_scorer.sv
`timescale 1ns/100ps
`default_nettype none

module rally_scorer (
    input  wire logic                      clk_25MHZ,
    input  wire logic                      reset,
    input  wire pong_link_pkg::rally_evt_t evt,
    output logic [7:0]                     score,
    output logic                           game_over,
    output logic                           send_trigger,
    output pong_field_pkg::vel_t           send_vy,
    output logic                           responding,
    output logic                           is_idle,
    output logic [7:0]                     leds
);

    logic in_stop;

    assign in_stop = (evt.phase == pong_link_pkg::stopped);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // score, game over and hand-off pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            score        <= '0;
            game_over    <= 1'b0;
            send_trigger <= 1'b0;
        end else begin
            send_trigger <= evt.returned;  // high for the cycle after send.
            if (game_over && !in_stop) begin
                score     <= '0;           // new game after the stop.
                game_over <= 1'b0;
            end else begin
                game_over <= in_stop;
                if (evt.returned) begin
                    score <= score + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (evt.returned) begin
            send_vy <= evt.vy;
        end
    end

    // status levels for the register slave and the board LEDs
    always_comb begin
        responding = (evt.phase == pong_link_pkg::wait_release);
        is_idle    = (evt.phase == pong_link_pkg::idle);
        case (evt.phase)
            pong_link_pkg::idle:         leds = 8'h01;
            pong_link_pkg::wait_release: leds = 8'h02;
            pong_link_pkg::stopped:      leds = 8'h04;
            pong_link_pkg::send:         leds = 8'h08;
            pong_link_pkg::fly_right:    leds = 8'h10;
            pong_link_pkg::fly_left:     leds = 8'h20;
            default:                     leds = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pong_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module pong_core_top #(
    parameter logic [19:0] TICK_BASE = 20'd600000
) (
    input  wire logic                  clk_25MHZ,
    input  wire logic                  reset,
    input  wire logic                  upscale,
    input  wire logic                  go_right,
    input  wire logic                  collision_detected,
    input  wire logic [9:0]            estimated_speed,
    input  wire logic [7:0]            reg_y0,
    input  wire logic [7:0]            reg_y1,
    input  wire logic signed [7:0]     reg_yspeed,
    input  wire logic [7:0]            reg_gravity,
    input  wire logic [7:0]            reg_kind,
    output pong_field_pkg::ball_pos_t  pos,
    output logic                       moving_right,
    output pong_field_pkg::ball_kind_t ball_kind,
    output logic [7:0]                 score,
    output logic                       game_over,
    output logic                       send_trigger,
    output pong_field_pkg::vel_t       send_vy,
    output logic                       responding,
    output logic                       is_idle,
    output logic [7:0]                 leds
);

    pong_link_pkg::serve_t     serve;
    pong_link_pkg::rally_evt_t evt;

    assign ball_kind = serve.kind;  // kind of the ball currently staged.

    serve_decoder #(
        .TICK_BASE (TICK_BASE)
    ) u_serve_decoder (
        .clk_25MHZ       (clk_25MHZ),
        .reset           (reset),
        .reg_y0          (reg_y0),
        .reg_y1          (reg_y1),
        .reg_yspeed      (reg_yspeed),
        .reg_gravity     (reg_gravity),
        .reg_kind        (reg_kind),
        .estimated_speed (estimated_speed),
        .serve           (serve)
    );

    ball_engine u_ball_engine (
        .clk_25MHZ          (clk_25MHZ),
        .reset              (reset),
        .upscale            (upscale),
        .go_right           (go_right),
        .collision_detected (collision_detected),
        .serve              (serve),
        .pos                (pos),
        .moving_right       (moving_right),
        .evt                (evt)
    );

    rally_scorer u_rally_scorer (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .evt          (evt),
        .score        (score),
        .game_over    (game_over),
        .send_trigger (send_trigger),
        .send_vy      (send_vy),
        .responding   (responding),
        .is_idle      (is_idle),
        .leds         (leds)
    );

endmodule

`default_nettype wire

//--- testbench/pong_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pong_core_tb;

    localparam int TICK = 200;
    localparam int MAX_PERIOD = (TICK * 26) / 20;                      // basket serve.
    localparam int CYCLE_LIMIT = (640 / 10) * (MAX_PERIOD + 1) * 5 + 2000;  // five serves.

    logic                       clk_25MHZ;
    logic                       reset;
    logic                       upscale;
    logic                       go_right;
    logic                       collision_detected;
    logic [9:0]                 estimated_speed;
    logic [7:0]                 reg_y0;
    logic [7:0]                 reg_y1;
    logic signed [7:0]          reg_yspeed;
    logic [7:0]                 reg_gravity;
    logic [7:0]                 reg_kind;
    pong_field_pkg::ball_pos_t  pos;
    logic                       moving_right;
    pong_field_pkg::ball_kind_t ball_kind;
    logic [7:0]                 score;
    logic                       game_over;
    logic                       send_trigger;
    pong_field_pkg::vel_t       send_vy;
    logic                       responding;
    logic                       is_idle;
    logic [7:0]                 leds;

    int                         errors;
    int                         cycles;
    logic [31:0]                rng_state;
    logic [7:0]                 expected_score;
    int                         model_x;
    int                         model_y;
    int                         model_vy;
    int                         model_gp;
    int                         y_max;
    int                         entry_y;
    int                         entry_vy;
    int                         entry_gp;
    int                         serve_per;
    int                         ret_per;
    pong_field_pkg::ball_kind_t exp_kind;

    pong_core_top #(
        .TICK_BASE (20'(TICK))
    ) uut (.*);

    always #20 clk_25MHZ = ~clk_25MHZ;

    always @(posedge clk_25MHZ) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic pos_is(input pong_field_pkg::ball_pos_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got (%0d,%0d) expected (%0d,%0d)",
                     $time, what, got.x, got.y, exp.x, exp.y);
        end
    endtask

    task automatic vel_is(input pong_field_pkg::vel_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic score_is(input logic [7:0] got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic leds_are(input logic [7:0] got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic flag_is(input logic got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic kind_is(input pong_field_pkg::ball_kind_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model of one flight step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic advance_model(input logic right);
        int y_sum;
        int vy_grav;
        y_sum    = model_y + model_vy;  // old velocity moves y.
        vy_grav  = (model_gp == 3) ? model_vy + 1 : model_vy;
        model_gp = (model_gp + 1) % 4;
        model_x  = right ? model_x + 10 : ((model_x >= 10) ? model_x - 10 : 0);
        if (y_sum >= y_max || y_sum <= 0) begin
            model_y  = (y_sum <= 0) ? 0 : y_max;
            model_vy = -vy_grav;
        end else begin
            model_y  = y_sum;
            model_vy = vy_grav;
        end
    endtask

    task automatic follow_steps(input int n_steps, input int period, input logic right);
        int gap;
        int seen;
        logic [9:0] last_x;
        pong_field_pkg::ball_pos_t want;
        gap    = 0;
        seen   = 0;
        last_x = pos.x;
        while (seen < n_steps) begin
            @(negedge clk_25MHZ);
            gap++;
            if (pos.x != last_x) begin
                if (gap != period + 1) begin
                    errors++;
                    $display("FAIL %0t: step came %0d cycles after the last, expected %0d",
                             $time, gap, period + 1);
                end
                advance_model(right);
                want.x = 10'(model_x);
                want.y = 10'(model_y);
                pos_is(pos, want, "position after step");
                vel_is(uut.u_ball_engine.vy, 10'(model_vy), "velocity after step");
                last_x = pos.x;
                gap    = 0;
                seen++;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_reset_state();
        pong_field_pkg::ball_pos_t want;
        @(negedge clk_25MHZ);
        want.x = pong_field_pkg::X_RESET;
        want.y = pong_field_pkg::Y_RESET;
        pos_is(pos, want, "position after reset");
        score_is(score, 8'd0, "score after reset");
        flag_is(is_idle, 1'b1, "is_idle after reset");
        leds_are(leds, 8'h01, "leds after reset");
        flag_is(game_over, 1'b0, "game_over after reset");
        flag_is(send_trigger, 1'b0, "send_trigger after reset");
        flag_is(moving_right, 1'b0, "moving_right after reset");
        flag_is(responding, 1'b0, "responding after reset");
    endtask

    task automatic stage_serve(input logic [7:0] y0, y1, input logic signed [7:0] speed,
                               input logic [7:0] grav, kind, input logic [9:0] est);
        @(negedge clk_25MHZ);
        reg_y0          = y0;
        reg_y1          = y1;
        reg_yspeed      = speed;
        reg_gravity     = grav;
        reg_kind        = kind;
        estimated_speed = est;
        entry_y  = {y0[7:6], y1};
        entry_vy = speed;
        entry_gp = grav[1:0];
        ret_per  = TICK / ((est < 2) ? 1 : est);
        case (kind[2:1])
            2'd1: begin
                exp_kind  = pong_field_pkg::soccer;
                serve_per = (TICK * 12) / 20;
            end
            2'd2: begin
                exp_kind  = pong_field_pkg::basket;
                serve_per = (TICK * 26) / 20;
            end
            default: begin
                exp_kind  = pong_field_pkg::pingpong;
                serve_per = (TICK * 9) / 20;
            end
        endcase
        repeat (2) @(negedge clk_25MHZ);  // serve stage is registered.
    endtask

    task automatic random_serve(input logic [9:0] est);
        logic [31:0] r;
        logic [31:0] s;
        r = lcg_next();
        s = lcg_next();
        stage_serve(r[31:24], r[23:16], $signed({5'd0, s[18:16]}) - 8'sd4, r[15:8], r[7:0], est);
    endtask

    task automatic launch_ball();
        pong_field_pkg::ball_pos_t want;
        go_right = 1'b1;
        @(negedge clk_25MHZ);
        want.x = pong_field_pkg::X_SERVE;
        want.y = 10'(entry_y);
        flag_is(responding, 1'b1, "responding while go_right held");
        leds_are(leds, 8'h02, "leds while waiting for release");
        kind_is(ball_kind, exp_kind, "ball kind");
        pos_is(pos, want, "launch position");
        go_right = 1'b0;
        @(negedge clk_25MHZ);
        flag_is(moving_right, 1'b1, "moving_right after release");
        leds_are(leds, 8'h10, "leds in right flight");
        model_x  = pong_field_pkg::X_SERVE;
        model_y  = entry_y;
        model_vy = entry_vy;
        model_gp = entry_gp;
        y_max    = (upscale ? pong_field_pkg::FIELD_H_FULL : pong_field_pkg::FIELD_H_HALF) - 1;
    endtask

    task automatic return_ball(input int n_right);
        follow_steps(n_right, serve_per, 1'b1);
        collision_detected = 1'b1;
        @(negedge clk_25MHZ);
        collision_detected = 1'b0;
        flag_is(moving_right, 1'b0, "moving_right after collision");
        leds_are(leds, 8'h20, "leds in left flight");
        follow_steps(model_x / 10, ret_per, 1'b0);
        @(negedge clk_25MHZ);
        leds_are(leds, 8'h08, "leds in send");
        flag_is(send_trigger, 1'b0, "send_trigger before hand-off");
        @(negedge clk_25MHZ);
        expected_score++;
        flag_is(send_trigger, 1'b1, "send_trigger at hand-off");
        vel_is(send_vy, 10'(model_vy), "send_vy at hand-off");
        score_is(score, expected_score, "score after return");
        leds_are(leds, 8'h01, "leds back in idle");
        @(negedge clk_25MHZ);
        flag_is(send_trigger, 1'b0, "send_trigger one cycle later");
    endtask

    task automatic lose_ball(input logic up);
        int waited;
        int width;
        upscale = up;
        width   = up ? pong_field_pkg::FIELD_W_FULL : pong_field_pkg::FIELD_W_HALF;
        random_serve(10'd4);
        launch_ball();
        follow_steps((width - pong_field_pkg::EDGE_MARGIN - pong_field_pkg::X_SERVE) / 10,
                     serve_per, 1'b1);
        waited = 0;
        while (!game_over && waited < 4) begin
            @(negedge clk_25MHZ);
            waited++;
        end
        flag_is(game_over, 1'b1, "game_over after missed ball");
        leds_are(leds, 8'h04, "leds in stop");
        go_right = 1'b1;  // restart pulse.
        @(negedge clk_25MHZ);
        go_right = 1'b0;
        @(negedge clk_25MHZ);
        expected_score = 8'd0;
        flag_is(game_over, 1'b0, "game_over after restart");
        flag_is(is_idle, 1'b1, "is_idle after restart");
        score_is(score, expected_score, "score after restart");
    endtask

    initial begin
        clk_25MHZ          = 1'b0;
        reset              = 1'b1;
        upscale            = 1'b0;
        go_right           = 1'b0;
        collision_detected = 1'b0;
        estimated_speed    = 10'd0;
        reg_y0             = 8'd0;
        reg_y1             = 8'd0;
        reg_yspeed         = 8'sd0;
        reg_gravity        = 8'd0;
        reg_kind           = 8'd0;
        errors             = 0;
        cycles             = 0;
        expected_score     = 8'd0;
        rng_state          = 32'hbb3681a8;
        repeat (16) @(negedge clk_25MHZ);
        reset = 1'b0;

        check_reset_state();
        random_serve(10'd0);
        launch_ball();
        return_ball(6);
        stage_serve(8'h00, 8'd100, -8'sd60, 8'h00, 8'h02, 10'd1);  // steep climb into both walls.
        launch_ball();
        return_ball(6);
        score_is(score, 8'd2, "score after two returns");
        random_serve(10'd7);
        launch_ball();
        return_ball(4);
        lose_ball(1'b0);
        lose_ball(1'b1);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/pong_field_pkg.sv
logic/pong_link_pkg.sv
logic/serve_decoder.sv
logic/ball_engine.sv
logic/rally_scorer.sv
logic/pong_core_top.sv
testbench/pong_core_tb.sv

//--- Bender.yml
package:
  name: pong_core

sources:
  - logic/pong_field_pkg.sv
  - logic/pong_link_pkg.sv
  - logic/serve_decoder.sv
  - logic/ball_engine.sv
  - logic/rally_scorer.sv
  - logic/pong_core_top.sv
  - target: simulation
    files:
      - testbench/pong_core_tb.sv
